/* filelist.f */
source/gba_load_pkg.sv
source/download_classify.sv
source/cart_scan.sv
source/quirk_detect.sv
source/halfword_assembler.sv
source/gba_loader_top.sv
verif/loader_checker.sv
verif/tb_gba_loader.sv

/* source/cart_scan.sv */
// Cartridge image scanner
`default_nettype none

module cart_scan (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  gba_load_pkg::stream_t    beat,
	input  gba_load_pkg::load_kind_t kind,
	output gba_load_pkg::cart_info_t info
);

	logic                loaded;
	logic [1:0]          cart_type;
	logic                flash_1m;
	gba_load_pkg::addr_t last_addr;
	gba_load_pkg::addr_t wr_addr;   // Address of the latest cart write
	logic [63:0]         history;   // Last eight image bytes, oldest on top

	logic        cart_wr;
	logic [71:0] mark_low;   // History plus the new low byte
	logic [71:0] mark_both;  // Seven history bytes plus both new bytes

	assign cart_wr = kind.cart_dl & beat.wr;

	// Marker may end on either byte of a halfword
	assign mark_low  = {history, beat.data[7:0]};
	assign mark_both = {history[55:0], beat.data[7:0], beat.data[15:8]};

	// ============================================================
	// Status flags
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			loaded    <= 1'b0;
			cart_type <= 2'b00;
			flash_1m  <= 1'b0;
		end else begin
			if (kind.cart_start) begin
				loaded    <= 1'b1;
				cart_type <= beat.index[7:6];  // Type bits ride on the index
				flash_1m  <= 1'b0;             // New image, forget old marker
			end
			if (cart_wr) begin
				if (mark_low == gba_load_pkg::FLASH_MARK)  flash_1m <= 1'b1;
				if (mark_both == gba_load_pkg::FLASH_MARK) flash_1m <= 1'b1;
			end
		end
	end

	// Byte history and addresses
	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			history <= {history[47:0], beat.data[7:0], beat.data[15:8]};
			wr_addr <= beat.addr;
		end
		if (kind.cart_end) last_addr <= wr_addr;  // Image size for the core
	end

	// Quirk fields belong to the quirk detector
	always_comb begin
		info                    = '0;
		info.loaded             = loaded;
		info.cart_type          = cart_type;
		info.flash_1m           = flash_1m;
		info.last_addr          = last_addr;
	end

endmodule

`default_nettype wire

/* source/download_classify.sv */
// Download stream classifier
`default_nettype none

module download_classify (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    ioctl_download,
	input  logic                    ioctl_wr,
	input  gba_load_pkg::addr_t     ioctl_addr,
	input  gba_load_pkg::half_t     ioctl_dout,
	input  gba_load_pkg::index_t    ioctl_index,
	output gba_load_pkg::stream_t   beat,
	output gba_load_pkg::load_kind_t kind
);

	logic                 wr_q;
	gba_load_pkg::addr_t  addr_q;
	gba_load_pkg::half_t  data_q;
	gba_load_pkg::index_t index_q;

	logic cart_dl, bios_dl, code_dl;       // Registered levels
	logic cart_dl_q, code_dl_q;            // One cycle older, for edges
	logic cart_start, cart_end, code_start;

	// Stream register, only the strobe is control
	always_ff @(posedge clk_sys) begin
		if (reset) wr_q <= 1'b0;
		else       wr_q <= ioctl_wr;
	end

	always_ff @(posedge clk_sys) begin
		addr_q  <= ioctl_addr;
		data_q  <= ioctl_dout;
		index_q <= ioctl_index;
	end

	// Kind decode and edge pulses
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			{cart_dl, bios_dl, code_dl} <= 3'b000;
			{cart_dl_q, code_dl_q}      <= 2'b00;
			{cart_start, cart_end, code_start} <= 3'b000;
		end else begin
			code_dl <= ioctl_download & (ioctl_index == gba_load_pkg::CODE_INDEX);
			bios_dl <= ioctl_download & (ioctl_index == gba_load_pkg::BIOS_INDEX);
			cart_dl <= ioctl_download & (ioctl_index != gba_load_pkg::CODE_INDEX)
			           & (ioctl_index != gba_load_pkg::BIOS_INDEX);
			cart_dl_q  <= cart_dl;
			code_dl_q  <= code_dl;
			cart_start <= cart_dl & ~cart_dl_q;  // Rise of the level
			cart_end   <= ~cart_dl & cart_dl_q;  // Fall of the level
			code_start <= code_dl & ~code_dl_q;
		end
	end

	assign beat = '{wr: wr_q, addr: addr_q, data: data_q, index: index_q};
	assign kind = '{cart_dl: cart_dl, bios_dl: bios_dl, code_dl: code_dl,
	                cart_start: cart_start, cart_end: cart_end, code_start: code_start};

	// Only one kind of download at a time
	a_one_level: assert property (@(posedge clk_sys) disable iff (reset)
		$onehot0({kind.cart_dl, kind.bios_dl, kind.code_dl}))
		else $error("download_classify: more than one download level set");

endmodule

`default_nettype wire

/* source/gba_load_pkg.sv */
// Loader shared definitions
`default_nettype none

package gba_load_pkg;

	// ============================================================
	// Stream widths
	// ============================================================
	typedef logic [26:0] addr_t;   // Byte address from the host
	typedef logic [15:0] half_t;   // One download halfword
	typedef logic [7:0]  index_t;  // File index from the menu

	// One registered beat of the download stream
	typedef struct packed {
		logic   wr;     // Halfword strobe
		addr_t  addr;
		half_t  data;   // Lower-address byte sits in bits 7:0
		index_t index;
	} stream_t;

	// Download levels and their edge pulses
	typedef struct packed {
		logic cart_dl;     // Levels, at most one set
		logic bios_dl;
		logic code_dl;
		logic cart_start;  // Single-cycle pulses
		logic cart_end;
		logic code_start;
	} load_kind_t;

	// ============================================================
	// Payloads
	// ============================================================
	typedef struct packed {
		logic [31:0] word;
	} bios_word_t;

	// Cheat record, big end first
	typedef struct packed {
		logic [31:0] flags;    // 127:96
		logic [31:0] address;  // 95:64
		logic [31:0] compare;  // 63:32
		logic [31:0] replace;  // 31:0
	} cheat_code_t;

	// Cartridge status seen by the core
	typedef struct packed {
		logic       loaded;
		logic [1:0] cart_type;           // Index bits 7:6
		logic       flash_1m;            // Marker found in image
		addr_t      last_addr;           // Highest written byte address
		logic       sram_quirk;
		logic       memory_remap_quirk;
	} cart_info_t;

	// File indices
	localparam index_t CODE_INDEX = 8'd255;
	localparam index_t BIOS_INDEX = 8'd0;  // Everything else is a cartridge

	// Header title location
	localparam addr_t TITLE_ADDR       = 27'h0A0;  // First title byte
	localparam int    TITLE_BYTES      = 12;
	localparam addr_t TITLE_MATCH_ADDR = 27'h0AC;  // Compare happens on this write

	// Flash 1M marker, 9 bytes
	localparam logic [71:0] FLASH_MARK = "FLASH1M_V";

	// ============================================================
	// Quirk table
	// ============================================================
	typedef struct packed {
		logic [95:0] title;  // Zero padded at the low end
		logic        sram;
		logic        remap;
	} quirk_t;

	localparam int QUIRK_COUNT = 6;

	localparam quirk_t quirk_table [QUIRK_COUNT] = '{
		'{"ROCKY BOXING",             1'b1, 1'b0},
		'{"DBZ TAIKETSU",             1'b1, 1'b0},
		'{{"IRIDIONII", 24'h000000},  1'b1, 1'b0},
		'{{"SUPER MARIO", 8'h00},     1'b1, 1'b1},  // NES classic re-release
		'{{"DR. MARIO", 24'h000000},  1'b1, 1'b1},
		'{"WRECKINGCREW",             1'b1, 1'b1}
	};

endpackage

`default_nettype wire

/* source/gba_loader_top.sv */
// Loader front end top
`default_nettype none

module gba_loader_top (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic                       ioctl_download,
	input  gba_load_pkg::index_t       ioctl_index,
	input  gba_load_pkg::addr_t        ioctl_addr,
	input  gba_load_pkg::half_t        ioctl_dout,
	input  logic                       ioctl_wr,
	input  logic                       homebrew_bios,  // Skip BIOS writes
	output logic [11:0]                bios_wraddr,
	output gba_load_pkg::bios_word_t   bios_wrdata,
	output logic                       bios_wr,
	output gba_load_pkg::cheat_code_t  cheat_code,
	output logic                       cheat_valid,
	output logic                       cheat_clear,
	output gba_load_pkg::cart_info_t   cart_info
);

	localparam int BIOS_FIELDS  = $bits(gba_load_pkg::bios_word_t) / 32;
	localparam int CHEAT_FIELDS = $bits(gba_load_pkg::cheat_code_t) / 32;

	gba_load_pkg::stream_t    beat;
	gba_load_pkg::load_kind_t kind;
	gba_load_pkg::cart_info_t scan_info;   // Scanner part, quirks zero
	logic                     sram_quirk;
	logic                     memory_remap_quirk;

	// ============================================================
	// Stream decode
	// ============================================================
	download_classify classify0 (
		.clk_sys, .reset,
		.ioctl_download, .ioctl_wr, .ioctl_addr, .ioctl_dout, .ioctl_index,
		.beat, .kind
	);

	// Cartridge status
	cart_scan scan0 (.clk_sys, .reset, .beat, .kind, .info(scan_info));

	quirk_detect quirk0 (
		.clk_sys, .reset, .beat, .kind,
		.sram_quirk, .memory_remap_quirk
	);

	// ============================================================
	// Payload builders
	// ============================================================
	halfword_assembler #(
		.payload_t (gba_load_pkg::bios_word_t),
		.FIELDS    (BIOS_FIELDS)
	) bios_asm0 (
		.clk_sys, .reset,
		.enable    (kind.bios_dl & ~homebrew_bios),  // Homebrew BIOS keeps its own image
		.beat,
		.payload   (bios_wrdata),
		.word_addr (bios_wraddr),
		.done      (bios_wr)
	);

	halfword_assembler #(
		.payload_t (gba_load_pkg::cheat_code_t),
		.FIELDS    (CHEAT_FIELDS)
	) cheat_asm0 (
		.clk_sys, .reset,
		.enable    (kind.code_dl),
		.beat,
		.payload   (cheat_code),
		.word_addr (),                  // Records carry their own address
		.done      (cheat_valid)
	);

	// Old cheat list goes when a new one starts
	assign cheat_clear = kind.code_start;

	// Merge scanner and quirk fields
	always_comb begin
		cart_info                    = scan_info;
		cart_info.sram_quirk         = sram_quirk;
		cart_info.memory_remap_quirk = memory_remap_quirk;
	end

endmodule

`default_nettype wire

/* source/halfword_assembler.sv */
// Halfword to payload assembler
`default_nettype none

module halfword_assembler #(
	parameter type payload_t = logic [31:0],
	parameter int  FIELDS    = 1            // Number of 32-bit fields
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  enable,
	input  gba_load_pkg::stream_t beat,
	output payload_t              payload,
	output logic [11:0]           word_addr,
	output logic                  done
);

	localparam int PAYLOAD_W = $bits(payload_t);
	localparam int SLOTS     = 2 * FIELDS;          // Halfwords per payload
	localparam int SLOT_W    = $clog2(SLOTS);
	localparam int POS_W     = $clog2(PAYLOAD_W);

	logic [PAYLOAD_W-1:0] payload_q;
	logic [SLOT_W-1:0]    slot;       // Halfword slot inside the payload
	logic [POS_W-1:0]     bit_lo;     // Low bit of the slot's half field
	logic                 take;
	logic                 last_slot;

	assign take      = enable & beat.wr;
	assign slot      = beat.addr[SLOT_W:1];           // Address over 2, modulo slots
	assign last_slot = (slot == SLOT_W'(SLOTS - 1));

	// Field slot/2 counted from the top, low half on even slots
	assign bit_lo = POS_W'(32 * (FIELDS - 1 - int'(slot >> 1)) + 16 * int'(slot[0]));

	// ============================================================
	// Payload fill
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (take) begin
			payload_q[bit_lo +: 16] <= beat.data;
			if (last_slot) word_addr <= beat.addr[13:2];  // Word address of the payload
		end
	end

	// Completion pulse
	always_ff @(posedge clk_sys) begin
		if (reset) done <= 1'b0;
		else       done <= take & last_slot;
	end

	assign payload = payload_t'(payload_q);

	// Host walks addresses upward, so completions are spaced
	a_done_single: assert property (@(posedge clk_sys) disable iff (reset)
		done |=> !done)
		else $error("halfword_assembler: done held for two cycles");

endmodule

`default_nettype wire

/* source/quirk_detect.sv */
// Header title quirk matcher
`default_nettype none

module quirk_detect (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  gba_load_pkg::stream_t    beat,
	input  gba_load_pkg::load_kind_t kind,
	output logic                     sram_quirk,
	output logic                     memory_remap_quirk
);

	localparam int TITLE_LAST = gba_load_pkg::TITLE_BYTES - 2;  // Offset of last halfword

	logic [95:0]         title;     // Title bytes, first byte on top
	gba_load_pkg::addr_t offset;    // Byte offset into the title
	logic [6:0]          title_lsb; // Bit position of the halfword
	logic                in_title;
	logic                at_match;
	logic                cart_wr;
	logic                hit_sram;
	logic                hit_remap;

	assign cart_wr  = kind.cart_dl & beat.wr;
	assign offset   = beat.addr - gba_load_pkg::TITLE_ADDR;
	assign in_title = (beat.addr >= gba_load_pkg::TITLE_ADDR)
	                  && (beat.addr < gba_load_pkg::TITLE_MATCH_ADDR);
	assign at_match = (beat.addr == gba_load_pkg::TITLE_MATCH_ADDR);

	// Earlier bytes land higher in the title
	assign title_lsb = 7'((TITLE_LAST - int'(offset[3:0])) * 8);

	// ============================================================
	// Title capture
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (cart_wr && in_title)
			title[title_lsb +: 16] <= {beat.data[7:0], beat.data[15:8]};  // Swap to big end
	end

	// Table lookup, any matching entry contributes its flags
	always_comb begin
		hit_sram  = 1'b0;
		hit_remap = 1'b0;
		for (int i = 0; i < gba_load_pkg::QUIRK_COUNT; i++) begin
			if (title == gba_load_pkg::quirk_table[i].title) begin
				hit_sram  = hit_sram | gba_load_pkg::quirk_table[i].sram;
				hit_remap = hit_remap | gba_load_pkg::quirk_table[i].remap;
			end
		end
	end

	// ============================================================
	// Quirk flags
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sram_quirk         <= 1'b0;
			memory_remap_quirk <= 1'b0;
		end else if (kind.cart_start) begin
			sram_quirk         <= 1'b0;  // Fresh cartridge, no quirks yet
			memory_remap_quirk <= 1'b0;
		end else if (cart_wr && at_match) begin
			if (hit_sram)  sram_quirk         <= 1'b1;
			if (hit_remap) memory_remap_quirk <= 1'b1;
		end
	end

	// Remap games always need the sram quirk as well
	a_remap_implies_sram: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(memory_remap_quirk) |-> sram_quirk)
		else $error("quirk_detect: remap set without sram quirk");

endmodule

`default_nettype wire

/* verif/loader_cases.txt */
# M homebrew | S index | W byte_addr halfwords bytes_in_address_order | E end of download
# B byte_addr bios_word | C cheat_record | X field value
X loaded 0
X sram 0
X remap 0
B 000 03020100
B 004 07060504
B 008 0B0A0908
B 00C 0F0E0D0C
S 00
W 000000 8 000102030405060708090A0B0C0D0E0F
E
M 1
S 00
W 000000 8 000102030405060708090A0B0C0D0E0F
E
M 0
C 13121110171615141B1A19181F1E1D1C
C 23222120272625242B2A29282F2E2D2C
S FF
W 000000 16 101112131415161718191A1B1C1D1E1F202122232425262728292A2B2C2D2E2F
E
X clears 1
S 41
W 0000A0 7 575245434B494E474352455700 00
E
X loaded 1
X type 1
X last 0000AC
X flash 0
X sram 1
X remap 1
S 01
W 0000A0 7 524F434B5920424F58494E470000
W 000200 5 464C415348314D5F5600
E
X flash 1
X sram 1
X remap 0
S 01
W 000300 5 00464C415348314D5F56
E
X flash 1
S 01
W 0000A0 7 48454C4C4F20574F524C44210000
E
X flash 0
X sram 0
X remap 0

/* verif/loader_checker.sv */
// Loader output checker
`default_nettype none

module loader_checker (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic [11:0]               bios_wraddr,
	input  gba_load_pkg::bios_word_t  bios_wrdata,
	input  logic                      bios_wr,
	input  gba_load_pkg::cheat_code_t cheat_code,
	input  logic                      cheat_valid,
	input  logic                      cheat_clear,
	input  gba_load_pkg::cart_info_t  cart_info,
	input  logic                      exp_valid,    // One expect line per pulse
	input  logic [7:0]                exp_op,       // B, C or X
	input  logic [127:0]              exp_field,    // Field name for X lines
	input  logic [127:0]              exp_value,
	output int                        pending,      // Pulses still awaited
	output int                        error_count
);

	logic [43:0]  bios_q [$];   // Word address over word data
	logic [127:0] cheat_q [$];
	logic [43:0]  bios_exp;
	logic [127:0] cheat_exp;
	int           clear_count;  // cheat_clear pulses seen so far

	task automatic compare(input string name, input logic [127:0] got,
	                       input logic [127:0] exp);
		if (got !== exp) begin
			error_count++;
			$display("[FAIL] %0t %s: got %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	// ============================================================
	// Status fields, checked when the line arrives
	// ============================================================
	task automatic check_field();
		case (exp_field)
			"loaded": compare("cart_info.loaded", 128'(cart_info.loaded), exp_value);
			"type":   compare("cart_info.cart_type", 128'(cart_info.cart_type), exp_value);
			"flash":  compare("cart_info.flash_1m", 128'(cart_info.flash_1m), exp_value);
			"last":   compare("cart_info.last_addr", 128'(cart_info.last_addr), exp_value);
			"sram":   compare("cart_info.sram_quirk", 128'(cart_info.sram_quirk), exp_value);
			"remap":
				compare("cart_info.memory_remap_quirk", 128'(cart_info.memory_remap_quirk),
				        exp_value);
			"clears": compare("cheat_clear count", 128'(clear_count), exp_value);
			default: begin
				error_count++;
				$display("An expect line names a field that does not exist");
			end
		endcase
	endtask

	// ============================================================
	// Pulse scoreboard
	// ============================================================
	always @(posedge clk_sys) begin
		if (!reset) begin
			if (exp_valid) begin
				case (exp_op)
					"B":     bios_q.push_back(exp_value[43:0]);  // Queued ahead of the download
					"C":     cheat_q.push_back(exp_value);
					default: check_field();
				endcase
			end
			if (cheat_clear) clear_count++;
			if (bios_wr) begin
				if (bios_q.size() == 0) begin
					error_count++;
					$display("BIOS write to word %0h that no expect line asked for", bios_wraddr);
				end else begin
					bios_exp = bios_q.pop_front();
					compare("bios_wraddr", 128'(bios_wraddr), 128'(bios_exp[43:32]));
					compare("bios_wrdata", 128'(bios_wrdata.word), 128'(bios_exp[31:0]));
				end
			end
			if (cheat_valid) begin
				if (clear_count == 0) begin
					error_count++;
					$display("Cheat record came out before any cheat_clear");
				end
				if (cheat_q.size() == 0) begin
					error_count++;
					$display("Cheat record %0h that no expect line asked for", cheat_code);
				end else begin
					cheat_exp = cheat_q.pop_front();
					compare("cheat_code", cheat_code, cheat_exp);  // Flags, address, compare, replace
				end
			end
			pending = bios_q.size() + cheat_q.size();
		end
	end

endmodule

`default_nettype wire

/* verif/tb_gba_loader.sv */
// Loader front end testbench
`default_nettype none

module tb_gba_loader;

	localparam int DRIVE_DELAY = 2;    // Inputs move this long after the rising edge
	localparam int TIMEOUT     = 100;  // Cycles allowed for any wait

	logic                      clk_sys;
	logic                      reset;
	logic                      ioctl_download;
	logic                      ioctl_wr;
	logic                      homebrew_bios;
	gba_load_pkg::index_t      ioctl_index;
	gba_load_pkg::addr_t       ioctl_addr;
	gba_load_pkg::half_t       ioctl_dout;
	logic [11:0]               bios_wraddr;
	gba_load_pkg::bios_word_t  bios_wrdata;
	logic                      bios_wr;
	gba_load_pkg::cheat_code_t cheat_code;
	logic                      cheat_valid;
	logic                      cheat_clear;
	gba_load_pkg::cart_info_t  cart_info;

	logic         exp_valid;
	logic [7:0]   exp_op;
	logic [127:0] exp_field;
	logic [127:0] exp_value;
	int           pending;
	int           checker_errors;
	int           tb_errors;
	int           seed_init;
	int           fd;

	gba_loader_top dut0 (
		.clk_sys, .reset, .ioctl_download, .ioctl_index, .ioctl_addr, .ioctl_dout,
		.ioctl_wr, .homebrew_bios, .bios_wraddr, .bios_wrdata, .bios_wr,
		.cheat_code, .cheat_valid, .cheat_clear, .cart_info
	);

	loader_checker check0 (
		.clk_sys, .reset, .bios_wraddr, .bios_wrdata, .bios_wr, .cheat_code,
		.cheat_valid, .cheat_clear, .cart_info, .exp_valid, .exp_op, .exp_field,
		.exp_value, .pending, .error_count(checker_errors)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;  // Period 20
	end

	task automatic step_clock();
		@(posedge clk_sys);
		#DRIVE_DELAY;
	endtask

	// One halfword after a random idle gap
	task automatic write_half(input gba_load_pkg::addr_t addr, input gba_load_pkg::half_t data);
		int gap;
		gap = $urandom % 3;
		repeat (gap) step_clock();
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr   = 1'b1;
		step_clock();
		ioctl_wr   = 1'b0;
	endtask

	// Bytes come in address order, lower-address byte into bits 7:0
	task automatic write_bytes(input gba_load_pkg::addr_t base, input int count,
	                           input logic [511:0] bytes);
		int k;
		int top;
		for (k = 0; k < count; k++) begin
			top = 2 * count - 1 - 2 * k;  // Position of byte 2k from the bottom
			write_half(base + 27'(2 * k), {bytes[(top - 1) * 8 +: 8], bytes[top * 8 +: 8]});
		end
	endtask

	// Byte list of a W line, blanks between digit groups are skipped
	task automatic read_hex_bytes(input int count, output logic [511:0] bytes);
		int         c;
		int         digits;
		logic [3:0] nib;
		logic       ok;
		bytes  = '0;
		digits = 0;
		ok     = 1'b1;
		while (ok && digits < 4 * count) begin
			c = $fgetc(fd);
			if (c == -1) ok = 1'b0;  // File ended early
			else if (c == " " || c == 9) begin
				// Blank between groups
			end else begin
				nib = 4'h0;
				if (c >= "0" && c <= "9")      nib = 4'(c - "0");
				else if (c >= "A" && c <= "F") nib = 4'(c - "A" + 10);
				else if (c >= "a" && c <= "f") nib = 4'(c - "a" + 10);
				else ok = 1'b0;  // Line ended before all bytes
				if (ok) begin
					bytes  = {bytes[507:0], nib};
					digits++;
				end
			end
		end
		if (!ok) begin
			tb_errors++;
			$display("A W line in the case file holds fewer bytes than it says");
		end
	endtask

	task automatic send_expect(input logic [7:0] op, input logic [127:0] field,
	                           input logic [127:0] value);
		exp_op    = op;
		exp_field = field;
		exp_value = value;
		exp_valid = 1'b1;
		step_clock();
		exp_valid = 1'b0;
	endtask

	// Until every queued pulse has shown up
	task automatic wait_idle();
		int cycles;
		cycles = 0;
		while (pending != 0 && cycles < TIMEOUT) begin
			step_clock();
			cycles++;
		end
		if (pending != 0) begin
			tb_errors++;
			$display("Timed out with %0d expected pulses still missing", pending);
		end
	endtask

	// ============================================================
	// Case file interpreter
	// ============================================================
	task automatic run_cases();
		logic [127:0]        op;
		logic [127:0]        field;
		logic [127:0]        value;
		logic [511:0]        bytes;
		logic [8*160-1:0]    line;
		gba_load_pkg::addr_t addr;
		int                  count;
		int                  code;
		logic                more;
		more = 1'b1;
		while (more) begin
			code = $fscanf(fd, " %s", op);
			if (code != 1) more = 1'b0;  // End of file
			else begin
				case (op)
					"#": code = $fgets(line, fd);
					"M": begin
						code = $fscanf(fd, " %h", value);
						homebrew_bios = value[0];
						step_clock();
					end
					"S": begin
						code = $fscanf(fd, " %h", value);
						ioctl_index    = value[7:0];
						ioctl_download = 1'b1;
						repeat (2) step_clock();  // Level and start pulse settle
					end
					"W": begin
						code = $fscanf(fd, " %h %d", addr, count);
						read_hex_bytes(count, bytes);
						write_bytes(addr, count, bytes);
					end
					"E": begin
						ioctl_download = 1'b0;
						repeat (4) step_clock();  // cart_end, then last_addr
						wait_idle();
					end
					"B": begin
						code = $fscanf(fd, " %h %h", addr, value);
						send_expect("B", '0, {84'h0, 12'(addr >> 2), value[31:0]});  // Word = byte / 4
					end
					"C": begin
						code = $fscanf(fd, " %h", value);
						send_expect("C", '0, value);
					end
					"X": begin
						code = $fscanf(fd, " %s %h", field, value);
						send_expect("X", field, value);
					end
					default: begin
						tb_errors++;
						$display("Unknown operation in the case file");
						more = 1'b0;
					end
				endcase
			end
		end
	endtask

	initial begin
		seed_init      = $urandom(69);  // Single seed for the whole run
		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_index    = '0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		homebrew_bios  = 1'b0;
		exp_valid      = 1'b0;
		exp_op         = '0;
		exp_field      = '0;
		exp_value      = '0;
		tb_errors      = 0;
		repeat (10) step_clock();
		reset = 1'b0;
		step_clock();
		fd = $fopen("verif/loader_cases.txt", "r");
		if (fd == 0) begin
			tb_errors++;
			$display("Cannot open the case file");
		end else begin
			run_cases();
			$fclose(fd);
		end
		wait_idle();
		$display("Errors: %0d from the checker, %0d from the testbench",
		         checker_errors, tb_errors);
		if (checker_errors + tb_errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire
